//--- build.f
source/iso14443a_pkg.sv
source/carrier_shaper.sv
source/subcarrier_detector.sv
source/frame_assembler.sv
source/byte_fifo.sv
source/host_link.sv
source/iso14443a_sniffer.sv
testbench/tb_clock.sv
testbench/sniffer_props.sv
testbench/tb_sniffer.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_sniffer
FILELIST  = build.f
BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(wildcard source/*.sv) $(wildcard testbench/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tb_sniffer.sv
//----------------------------------------------------------------------
// directed testbench for the ISO14443-A sniff and listen path
// stimulus changes 1 ns after each rising pck0 edge, the host model
// answers req/ack in the same slot, every check stops the run
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_sniffer;
	import iso14443a_pkg::*;

	// cycles per test including its reset, plus slack for the drain
	localparam int run_cycles = 16 * 5 + 520 + 330 + 720 + 1040 + 700;
	localparam int margin_cycles = 500;

	logic pck0;
	logic reset_init;
	logic test_reset;
	wire fdt_reset = reset_init | test_reset;
	mode_t mode_sel;
	sample_t adc_d;
	host_req_t host_out;
	logic host_ack;
	logic overflow;
	logic ack_hold;
	logic [7:0] lfsr_state;
	host_byte_t received[$];

	tb_clock clock_gen (
		.pck0 (pck0),
		.reset_init (reset_init)
	);

	iso14443a_sniffer DUT (
		.pck0 (pck0),
		.fdt_reset (fdt_reset),
		.mode (mode_sel),
		.adc_d (adc_d),
		.host (host_out),
		.host_ack (host_ack),
		.overflow (overflow)
	);

	//------------------------------------------------------------------
	// noise source, x^8 + x^6 + x^5 + x^4 + 1
	//------------------------------------------------------------------
	function automatic logic next_bit();
		logic fb;
		fb = lfsr_state[7] ^ lfsr_state[5] ^ lfsr_state[4] ^ lfsr_state[3];
		lfsr_state = {lfsr_state[6:0], fb};
		return fb;
	endfunction

	// three bits give 0..7, folded into 9..15 so the hysteresis never trips
	function automatic sample_t noise_level();
		logic [2:0] r;
		r[0] = next_bit();
		r[1] = next_bit();
		r[2] = next_bit();
		return sample_t'(9 + (r % 7));
	endfunction

	// sniff byte as the packing rule defines it
	function automatic host_byte_t sniff_byte(input logic [3:0] reader_nib,
		input logic [3:0] tag_nib, input logic deep);
		return deep ? {reader_nib, 4'h0} : {reader_nib, tag_nib};
	endfunction

	//------------------------------------------------------------------
	// compare tasks
	//------------------------------------------------------------------
	task automatic compare_byte(input string name, input host_byte_t got,
		input host_byte_t exp);
		if (got !== exp)
		begin
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	//------------------------------------------------------------------
	// stimulus helpers
	//------------------------------------------------------------------
	// one sample per cycle, seen by the DUT at the next rising edge
	task automatic step(input sample_t level);
		adc_d = level;
		@(posedge pck0);
		#1;
	endtask

	// after this the first sample driven meets bit counter 0
	task automatic apply_reset(input mode_t mode);
		mode_sel = mode;
		adc_d = sample_t'(200);
		test_reset = 1'b1;
		repeat (16) @(posedge pck0);
		#1;
		test_reset = 1'b0;
		received.delete();
	endtask

	task automatic wait_bytes(input int count, input sample_t level, input int limit);
		int k;
		k = 0;
		while (received.size() < count)
		begin
			if (k >= limit)
			begin
				$display("only %0d of %0d bytes arrived within %0d cycles",
					received.size(), count, limit);
				$display("Some tests failed");
				$fatal(1);
			end
			step(level);
			k++;
		end
	endtask

	// host side of the four-phase handshake, ack_hold parks ack high
	initial
	begin
		host_ack = 1'b0;
		forever
		begin
			@(posedge pck0);
			#1;
			if (ack_hold)
				host_ack = 1'b1;
			else if (host_out.req && !host_ack)
			begin
				received.push_back(host_out.data);
				host_ack = 1'b1;
			end
			else if (!host_out.req && host_ack)
				host_ack = 1'b0;
		end
	end

	//------------------------------------------------------------------
	// directed tests
	//------------------------------------------------------------------
	task automatic steady_carrier_test();
		apply_reset(mode_sniff);
		compare_flag("host.req after reset", host_out.req, 1'b0);
		wait_bytes(6, sample_t'(200), 520);
		for (int i = 2; i < 6; i++)
			compare_byte("steady sniff byte", received[i], sniff_byte(4'hf, 4'h0, 1'b0));
		compare_flag("overflow", overflow, 1'b0);
	endtask

	// the pause starts one sample early so reader_bit is 0 from counter 0
	// a short tag burst ahead of it leaves a tag bit in the pause byte
	// that only deep modulation clears
	task automatic reader_pause_test();
		apply_reset(mode_sniff);
		repeat (96) step(sample_t'(200));
		for (int i = 0; i < 31; i++)
			step(((i / 8) % 2) ? sample_t'(100) : sample_t'(200));
		repeat (64) step(sample_t'(0));
		wait_bytes(3, sample_t'(200), 200);
		compare_byte("byte before pause", received[1], sniff_byte(4'hf, 4'h0, 1'b0));
		compare_byte("byte of pause", received[2], sniff_byte(4'h0, 4'h8, 1'b1));
	endtask

	// noise may trip the edge filter, so only the reader nibble is checked
	task automatic hysteresis_test();
		apply_reset(mode_sniff);
		repeat (128) step(sample_t'(200));
		repeat (256) step(noise_level());
		repeat (64) step(sample_t'(3));
		repeat (256) step(noise_level());
		wait_bytes(11, sample_t'(3), 100);
		for (int i = 2; i < 6; i++)
			compare_byte("reader nibble held high", received[i] & 8'hf0, 8'hf0);
		for (int i = 7; i < 11; i++)
			compare_byte("reader nibble held low", received[i] & 8'hf0, 8'h00);
	endtask

	task automatic tag_modulation_test();
		apply_reset(mode_listen);
		for (int i = 0; i < 512; i++)
			step(((i / 8) % 2) ? sample_t'(100) : sample_t'(200));
		repeat (512) step(sample_t'(150));
		wait_bytes(8, sample_t'(150), 300);
		for (int i = 1; i < 4; i++)
			compare_byte("modulated listen byte", received[i], 8'hff);
		for (int i = 5; i < 8; i++)
			compare_byte("flat listen byte", received[i], 8'h00);
	endtask

	// ack held high keeps the link idle, so the FIFO alone stores bytes
	task automatic back_pressure_test();
		host_byte_t expected[fifo_depth];
		expected[0] = sniff_byte(4'b0111, 4'h0, 1'b0);
		for (int i = 1; i < fifo_depth; i++)
			expected[i] = sniff_byte(4'hf, 4'h0, 1'b0);
		ack_hold = 1'b1;
		apply_reset(mode_sniff);
		repeat (640) step(sample_t'(200));
		ack_hold = 1'b0;
		repeat (40) step(sample_t'(200));
		if (received.size() != fifo_depth)
		begin
			$display("%0d bytes delivered after back-pressure, %0d expected",
				received.size(), fifo_depth);
			$display("Some tests failed");
			$fatal(1);
		end
		for (int i = 0; i < fifo_depth; i++)
			compare_byte("queued byte", received[i], expected[i]);
		compare_flag("overflow", overflow, 1'b1);
	endtask

	//------------------------------------------------------------------
	// sequence and watchdog
	//------------------------------------------------------------------
	initial
	begin
		lfsr_state = 8'd47;
		ack_hold = 1'b0;
		test_reset = 1'b1;
		mode_sel = mode_sniff;
		adc_d = '0;
		steady_carrier_test();
		reader_pause_test();
		hysteresis_test();
		tag_modulation_test();
		back_pressure_test();
		if (DUT.props.error_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	initial
	begin
		#((run_cycles + margin_cycles) * 8);
		$display("watchdog expired before the tests completed");
		$display("Some tests failed");
		$fatal(1);
	end

endmodule

`default_nettype wire

//--- testbench/sniffer_props.sv
//----------------------------------------------------------------------
// concurrent checks on the req/ack link and the FIFO overflow flag
// bound into the top level, where host, host_ack and overflow all meet
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module sniffer_props (
	input wire pck0,
	input wire fdt_reset,
	input wire iso14443a_pkg::host_req_t host,
	input wire host_ack,
	input wire overflow
);
	import iso14443a_pkg::*;

	// number of failed assertions
	int error_count = 0;

	// the byte on offer must not move while req is up
	data_stable: assert property (@(posedge pck0) disable iff (fdt_reset)
		(host.req && $past(host.req)) |-> (host.data == $past(host.data)))
		else
		begin
			error_count++;
			$error("host data changed while req was high");
		end

	// a new req only starts once the host has released ack
	req_after_ack_low: assert property (@(posedge pck0) disable iff (fdt_reset)
		$rose(host.req) |-> !$past(host_ack))
		else
		begin
			error_count++;
			$error("req rose while ack was still high");
		end

	// overflow clears only through reset
	overflow_sticky: assert property (@(posedge pck0) disable iff (fdt_reset)
		$past(overflow) |-> overflow)
		else
		begin
			error_count++;
			$error("overflow cleared without reset");
		end

endmodule

bind iso14443a_sniffer sniffer_props props (
	.pck0 (pck0),
	.fdt_reset (fdt_reset),
	.host (host),
	.host_ack (host_ack),
	.overflow (overflow)
);

`default_nettype wire

//--- testbench/tb_clock.sv
//----------------------------------------------------------------------
// testbench clock and power-on reset
// pck0 has an 8 ns period, reset is held for the first 16 rising edges
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
	output logic pck0,
	output logic reset_init
);
	initial
	begin
		pck0 = 1'b0;
		forever
			#4 pck0 = ~pck0;
	end

	// release lands 1 ns after an edge, like all other stimulus
	initial
	begin
		reset_init = 1'b1;
		repeat (16) @(posedge pck0);
		#1 reset_init = 1'b0;
	end

endmodule

`default_nettype wire

//--- source/iso14443a_sniffer.sv
//----------------------------------------------------------------------
// ISO14443-A receive path top level, sniff and reader-listen modes
// one adc_d sample per pck0 cycle, bytes go out over req/ack
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module iso14443a_sniffer (
	input wire pck0,
	input wire fdt_reset,
	input wire iso14443a_pkg::mode_t mode,
	input wire iso14443a_pkg::sample_t adc_d,
	output iso14443a_pkg::host_req_t host,
	input wire host_ack,
	output logic overflow
);
	import iso14443a_pkg::*;

	carrier_status_t status;
	logic [phase_w-1:0] phase;
	logic tag_bit;
	logic wr_en;
	host_byte_t wr_data;
	logic rd_en;
	logic not_empty;
	host_byte_t head;

	//------------------------------------------------------------------
	// producer side
	//------------------------------------------------------------------
	carrier_shaper u_shaper (
		.pck0 (pck0),
		.fdt_reset (fdt_reset),
		.adc_d (adc_d),
		.status (status)
	);

	subcarrier_detector u_detector (
		.pck0 (pck0),
		.fdt_reset (fdt_reset),
		.adc_d (adc_d),
		.phase (phase),
		.tag_bit (tag_bit)
	);

	frame_assembler u_assembler (
		.pck0 (pck0),
		.fdt_reset (fdt_reset),
		.mode (mode),
		.status (status),
		.tag_bit (tag_bit),
		.phase (phase),
		.wr_en (wr_en),
		.wr_data (wr_data)
	);

	//------------------------------------------------------------------
	// buffer and host side
	//------------------------------------------------------------------
	byte_fifo u_fifo (
		.pck0 (pck0),
		.fdt_reset (fdt_reset),
		.wr_en (wr_en),
		.wr_data (wr_data),
		.rd_en (rd_en),
		.not_empty (not_empty),
		.head (head),
		.overflow (overflow)
	);

	host_link u_link (
		.pck0 (pck0),
		.fdt_reset (fdt_reset),
		.not_empty (not_empty),
		.head (head),
		.rd_en (rd_en),
		.host (host),
		.host_ack (host_ack)
	);

endmodule

`default_nettype wire

//--- source/host_link.sv
//----------------------------------------------------------------------
// four-phase req/ack byte sender
// data is held from the rise of req until the host drops ack
// a new req needs ack seen low in idle first
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module host_link (
	input wire pck0,
	input wire fdt_reset,
	input wire not_empty,
	input wire iso14443a_pkg::host_byte_t head,
	output logic rd_en,
	output iso14443a_pkg::host_req_t host,
	input wire host_ack
);
	import iso14443a_pkg::*;

	typedef enum logic [1:0] {
		idle,
		wait_ack_high,
		wait_ack_low
	} link_state_t;

	link_state_t state;
	host_byte_t data_q;

	// take the head only when the host has released the previous byte
	assign rd_en = (state == idle) && not_empty && !host_ack;

	always_ff @(posedge pck0)
	begin
		if (fdt_reset)
		begin
			state <= idle;
		end
		else
		begin
			case (state)
				idle:
					if (rd_en)
						state <= wait_ack_high;
				wait_ack_high:
					if (host_ack)
						state <= wait_ack_low;
				wait_ack_low:
					if (!host_ack)
						state <= idle;
				default:
					state <= idle;
			endcase
		end
	end

	always_ff @(posedge pck0)
	begin
		if (rd_en)
			data_q <= head;
	end

	// req is high for exactly the wait_ack_high state
	assign host = '{req: (state == wait_ack_high), data: data_q};

endmodule

`default_nettype wire

//--- source/byte_fifo.sv
//----------------------------------------------------------------------
// byte FIFO with show-ahead read
// a write into a full FIFO is lost and overflow stays set until reset
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module byte_fifo (
	input wire pck0,
	input wire fdt_reset,
	input wire wr_en,
	input wire iso14443a_pkg::host_byte_t wr_data,
	input wire rd_en,
	output logic not_empty,
	output iso14443a_pkg::host_byte_t head,
	output logic overflow
);
	import iso14443a_pkg::*;

	host_byte_t mem [fifo_depth];
	logic [fifo_ptr_w-1:0] wr_ptr;
	logic [fifo_ptr_w-1:0] rd_ptr;
	logic [fifo_ptr_w:0] count;
	logic full;
	logic do_wr;
	logic do_rd;

	assign full = (count == (fifo_ptr_w + 1)'(fifo_depth));
	assign not_empty = (count != '0);
	// fullness is judged before any read of the same cycle
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && not_empty;
	assign head = mem[rd_ptr];

	always_ff @(posedge pck0)
	begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	//------------------------------------------------------------------
	// pointers wrap naturally since the depth is a power of two
	//------------------------------------------------------------------
	always_ff @(posedge pck0)
	begin
		if (fdt_reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
			if (wr_en && full)
				overflow <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- source/frame_assembler.sv
//----------------------------------------------------------------------
// bit timing, bit sampling and byte packing
// mode is taken only while fdt_reset is high
// bytes leave as one-cycle pulses, nothing here waits for the FIFO
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module frame_assembler (
	input wire pck0,
	input wire fdt_reset,
	input wire iso14443a_pkg::mode_t mode,
	input wire iso14443a_pkg::carrier_status_t status,
	input wire tag_bit,
	output logic [iso14443a_pkg::phase_w-1:0] phase,
	output logic wr_en,
	output iso14443a_pkg::host_byte_t wr_data
);
	import iso14443a_pkg::*;

	mode_t mode_q;
	// 128 cycles cover the eight bits of one listen byte
	logic [6:0] bit_cnt;
	logic [3:0] reader_sr;
	logic [7:0] tag_sr;
	logic sample_point;
	logic load_sniff;
	logic load_listen;

	always_ff @(posedge pck0)
	begin
		if (fdt_reset)
			mode_q <= mode;
	end

	//------------------------------------------------------------------
	// bit period counter, free running from 0 to 127
	//------------------------------------------------------------------
	always_ff @(posedge pck0)
	begin
		if (fdt_reset)
			bit_cnt <= '0;
		else
			bit_cnt <= bit_cnt + 1'b1;
	end

	// the detector window is keyed to the same phase
	assign phase = bit_cnt[phase_w-1:0];
	assign sample_point = (phase == '0);
	assign load_sniff = (mode_q == mode_sniff) && (bit_cnt[5:0] == 6'd63);
	assign load_listen = (mode_q == mode_listen) && (bit_cnt == 7'd127);

	//------------------------------------------------------------------
	// bit sampling, newest bit enters at the LSB
	//------------------------------------------------------------------
	always_ff @(posedge pck0)
	begin
		if (sample_point)
		begin
			reader_sr <= {reader_sr[2:0], status.reader_bit};
			tag_sr <= {tag_sr[6:0], tag_bit};
		end
	end

	//------------------------------------------------------------------
	// byte packing
	//------------------------------------------------------------------
	always_ff @(posedge pck0)
	begin
		if (fdt_reset)
			wr_en <= 1'b0;
		else
			wr_en <= load_sniff || load_listen;
	end

	always_ff @(posedge pck0)
	begin
		if (load_sniff)
		begin
			// while a reader talks the tag nibble would only carry its pauses
			if (status.deep_mod)
				wr_data <= {reader_sr, 4'b0000};
			else
				wr_data <= {reader_sr, tag_sr[3:0]};
		end
		else if (load_listen)
		begin
			wr_data <= tag_sr;
		end
	end

endmodule

`default_nettype wire

//--- source/subcarrier_detector.sv
//----------------------------------------------------------------------
// tag load modulation detector
// a gaussian derivative filter over five samples feeds an edge maximum
// search, one decision per window at phase window_phase
// the window phase is fixed, no realignment to reader edges
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module subcarrier_detector (
	input wire pck0,
	input wire fdt_reset,
	input wire iso14443a_pkg::sample_t adc_d,
	input wire [iso14443a_pkg::phase_w-1:0] phase,
	output logic tag_bit
);
	import iso14443a_pkg::*;

	// sample history, prev_4 is the oldest
	sample_t prev_4;
	sample_t prev_3;
	sample_t prev_2;
	sample_t prev_1;
	logic [10:0] lead_sum;
	logic [10:0] trail_sum;
	filter_t filtered;
	// steepest falling edge gives the positive peak, rising the negative
	filter_t pos_max;
	filter_t neg_min;

	always_ff @(posedge pck0)
	begin
		prev_4 <= prev_3;
		prev_3 <= prev_2;
		prev_2 <= prev_1;
		prev_1 <= adc_d;
	end

	//------------------------------------------------------------------
	// filter taps are 2, 1, 0, -1, -2 from oldest to current
	//------------------------------------------------------------------
	// both sums stay below 766 so the difference fits 11 signed bits
	assign lead_sum = {2'b00, prev_4, 1'b0} + {3'b000, prev_3};
	assign trail_sum = {2'b00, adc_d, 1'b0} + {3'b000, prev_1};
	assign filtered = filter_t'(lead_sum - trail_sum);

	//------------------------------------------------------------------
	// per window decision
	//------------------------------------------------------------------
	always_ff @(posedge pck0)
	begin
		if (fdt_reset)
		begin
			tag_bit <= 1'b0;
			pos_max <= '0;
			neg_min <= '0;
		end
		else if (phase == phase_w'(window_phase))
		begin
			// modulation needs a strong edge in both directions
			tag_bit <= (pos_max > filter_t'(edge_threshold)) &&
				(neg_min < -filter_t'(edge_threshold));
			// the sample at the decision point opens the next window
			pos_max <= (filtered > 0) ? filtered : '0;
			neg_min <= (filtered < 0) ? filtered : '0;
		end
		else if (filtered > 0)
		begin
			if (filtered > pos_max)
				pos_max <= filtered;
		end
		else
		begin
			if (filtered < neg_min)
				neg_min <= filtered;
		end
	end

endmodule

`default_nettype wire

//--- source/carrier_shaper.sv
//----------------------------------------------------------------------
// reader pause shaping with a hysteresis and deep modulation detection
// reader_bit lags adc_d by one cycle, levels between the thresholds hold
// there is no field-loss timeout, a dead field reads as a long pause
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module carrier_shaper (
	input wire pck0,
	input wire fdt_reset,
	input wire iso14443a_pkg::sample_t adc_d,
	output iso14443a_pkg::carrier_status_t status
);
	import iso14443a_pkg::*;

	logic reader_bit;
	logic deep_mod;
	// run lengths of zero and non-zero samples
	logic [deep_on_w-1:0] zero_run;
	logic [deep_off_w-1:0] live_run;

	//------------------------------------------------------------------
	// hysteresis, a Schmitt trigger against slowly moving carrier edges
	//------------------------------------------------------------------
	always_ff @(posedge pck0)
	begin
		if (fdt_reset)
		begin
			reader_bit <= 1'b0;
		end
		else if (adc_d >= sample_t'(hyst_high))
		begin
			reader_bit <= 1'b1;
		end
		else if (adc_d < sample_t'(hyst_low))
		begin
			reader_bit <= 1'b0;
		end
	end

	//------------------------------------------------------------------
	// deep modulation, set by a run of zero samples and cleared by a
	// much longer run of carrier
	//------------------------------------------------------------------
	always_ff @(posedge pck0)
	begin
		if (fdt_reset)
		begin
			deep_mod <= 1'b0;
			zero_run <= '0;
			live_run <= '0;
		end
		else if (adc_d == '0)
		begin
			// any zero sample breaks the carrier run
			live_run <= '0;
			if (zero_run == deep_on_w'(deep_on_count - 1))
				deep_mod <= 1'b1;
			else
				zero_run <= zero_run + 1'b1;
		end
		else
		begin
			zero_run <= '0;
			if (live_run == deep_off_w'(deep_off_count - 1))
				deep_mod <= 1'b0;
			else
				live_run <= live_run + 1'b1;
		end
	end

	assign status = '{reader_bit: reader_bit, deep_mod: deep_mod};

endmodule

`default_nettype wire

//--- source/iso14443a_pkg.sv
//----------------------------------------------------------------------
// shared constants and types for the ISO14443-A sniff and listen path
// all levels are raw ADC codes, all times are pck0 cycles
// the derived widths assume the counts are powers of two
//----------------------------------------------------------------------
`default_nettype none

package iso14443a_pkg;

	// ADC and reader pause shaping
	localparam int sample_w = 8;
	localparam int hyst_high = 16;
	localparam int hyst_low = 8;
	localparam int deep_on_count = 8;
	localparam int deep_off_count = 256;
	localparam int deep_on_w = $clog2(deep_on_count);
	localparam int deep_off_w = $clog2(deep_off_count);

	// tag edge detector and bit timing
	localparam int edge_threshold = 5;
	localparam int bit_period = 16;
	localparam int phase_w = $clog2(bit_period);
	localparam int window_phase = 4;

	// host side buffering
	localparam int fifo_depth = 4;
	localparam int fifo_ptr_w = $clog2(fifo_depth);

	typedef logic [sample_w-1:0] sample_t;
	typedef logic signed [10:0] filter_t;
	typedef logic [7:0] host_byte_t;

	// sniff samples reader and tag, listen samples the tag only
	typedef enum logic {
		mode_sniff = 1'b0,
		mode_listen = 1'b1
	} mode_t;

	typedef struct packed {
		logic reader_bit;
		logic deep_mod;
	} carrier_status_t;

	typedef struct packed {
		logic req;
		host_byte_t data;
	} host_req_t;

endpackage

`default_nettype wire
